//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module gmii_rx_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_gmii_rx -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir

//--- gmii_rx_params.svh
`ifndef GMII_RX_PARAMS_SVH
`define GMII_RX_PARAMS_SVH

// ------------------------------------------------------------
// header match values
// ------------------------------------------------------------
`define GMII_ETH_TYPE   16'h0800
`define GMII_IP_VER     8'h45
`define GMII_IP_PROTO   8'h11
// base address, low byte gets board_id added
`define GMII_DST_IP     {8'd192, 8'd168, 8'd0, 8'd1}
`define GMII_DST_PORT   16'd12345

// ------------------------------------------------------------
// payload layout, frame byte indices with preamble counted
// ------------------------------------------------------------
`define GMII_INFO_OFS   50
`define GMII_VIDEO_END  1252
// data bytes per aux block, after the two position bytes
`define GMII_AUX_BLOCK  36

// fifo address width
`define FIFO_DEPTH_LOG2 4

`endif

//--- gmii_rx_pkg.sv
`default_nettype none

package gmii_rx_pkg;

	// low nibble of the packet-info byte
	typedef enum logic [3:0] {
		MODE_VIDEO = 4'd0,
		MODE_AUDIO = 4'd1,
		MODE_VIDAX = 4'd2
	} pkt_mode_t;

	// one pixel pair with its line position
	typedef struct packed {
		logic        x_lsb;
		logic [10:0] line;
		logic [7:0]  pix_a;
		logic [7:0]  pix_b;
	} video_word_t;

	// one nine-bit aux sample tagged with its block position
	typedef struct packed {
		logic [2:0]  pad;
		logic [15:0] pos;
		logic [8:0]  sample;
	} aux_word_t;

	// same 28 bits, read by is_aux
	typedef union packed {
		video_word_t video;
		aux_word_t   aux;
	} payload_u;

	typedef struct packed {
		logic     is_aux;
		logic     last;
		payload_u body;
	} fifo_entry_t;

endpackage

`default_nettype wire

//--- gmii_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module gmii_rx_top
	import gmii_rx_pkg::*;
(
	input  logic        clk125,
	input  logic        sys_rst,
	input  logic        board_id,
	input  logic [7:0]  rxd,
	input  logic        rx_dv,
	output logic        video_valid,
	output video_word_t video,
	output logic        aux_valid,
	output aux_word_t   aux,
	output logic        video_done,
	output logic        aux_done
);

	fifo_entry_t wr_entry;
	fifo_entry_t head;
	logic        wr;
	logic        rd;
	logic        empty;

	// ------------------------------------------------------------
	// parser, buffer, router
	// ------------------------------------------------------------
	udp_stream_parser i_parser (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.board_id (board_id),
		.rxd      (rxd),
		.rx_dv    (rx_dv),
		.entry    (wr_entry),
		.wr       (wr)
	);

	// full is only watched by the fifo's own check
	stream_fifo i_fifo (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.wr_entry (wr_entry),
		.wr       (wr),
		.rd       (rd),
		.rd_entry (head),
		.empty    (empty),
		.full     ()
	);

	stream_router i_router (
		.clk125      (clk125),
		.sys_rst     (sys_rst),
		.head        (head),
		.empty       (empty),
		.rd          (rd),
		.video_valid (video_valid),
		.video       (video),
		.aux_valid   (aux_valid),
		.aux         (aux),
		.video_done  (video_done),
		.aux_done    (aux_done)
	);

endmodule

`default_nettype wire

//--- list.f
+incdir+.
gmii_rx_pkg.sv
udp_stream_parser.sv
stream_fifo.sv
stream_router.sv
gmii_rx_top.sv
tb_gmii_rx.sv

//--- stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "gmii_rx_params.svh"

module stream_fifo
	import gmii_rx_pkg::*;
(
	input  logic        clk125,
	input  logic        sys_rst,
	input  fifo_entry_t wr_entry,
	input  logic        wr,
	input  logic        rd,
	output fifo_entry_t rd_entry,
	output logic        empty,
	output logic        full
);

	localparam logic [`FIFO_DEPTH_LOG2:0] DEPTH = 1 << `FIFO_DEPTH_LOG2;

	fifo_entry_t                 mem [0:DEPTH-1];
	logic [`FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [`FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic [`FIFO_DEPTH_LOG2:0]   count;
	logic                        do_wr;
	logic                        do_rd;

	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	assign empty    = count == '0;
	assign full     = count == DEPTH;
	assign rd_entry = mem[rd_ptr];

	always_ff @(posedge clk125) begin
		if (do_wr)
			mem[wr_ptr] <= wr_entry;
	end

	// ------------------------------------------------------------
	// pointers and fill count
	// ------------------------------------------------------------
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// parser never outruns the router drain
	a_no_overflow: assert property (@(posedge clk125) disable iff (sys_rst)
		wr |-> !full);

	a_no_underflow: assert property (@(posedge clk125) disable iff (sys_rst)
		rd |-> !empty);

endmodule

`default_nettype wire

//--- stream_router.sv
`timescale 1ns/1ps
`default_nettype none

module stream_router
	import gmii_rx_pkg::*;
(
	input  logic        clk125,
	input  logic        sys_rst,
	input  fifo_entry_t head,
	input  logic        empty,
	output logic        rd,
	output logic        video_valid,
	output video_word_t video,
	output logic        aux_valid,
	output aux_word_t   aux,
	output logic        video_done,
	output logic        aux_done
);

	// drain one entry whenever there is one
	assign rd = !empty;

	// ------------------------------------------------------------
	// strobes
	// ------------------------------------------------------------
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			video_valid <= 1'b0;
			aux_valid   <= 1'b0;
			video_done  <= 1'b0;
			aux_done    <= 1'b0;
		end else begin
			video_valid <= rd && !head.is_aux;
			aux_valid   <= rd && head.is_aux;
			video_done  <= rd && !head.is_aux && head.last;
			aux_done    <= rd && head.is_aux && head.last;
		end
	end

	// union read by tag
	always_ff @(posedge clk125) begin
		if (rd) begin
			if (head.is_aux)
				aux <= head.body.aux;
			else
				video <= head.body.video;
		end
	end

endmodule

`default_nettype wire

//--- tb_packet_gen.svh
`ifndef TB_PACKET_GEN_SVH
`define TB_PACKET_GEN_SVH

// bytes of the next frame, preamble included
logic [7:0]  frame[$];
logic [15:0] lfsr_state = 16'd78;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [7:0] rand_byte();
	logic [7:0] b;
	for (int i = 0; i < 8; i++) begin
		b[i] = lfsr_state[15];
		lfsr_state = lfsr_next(lfsr_state);
	end
	return b;
endfunction

// header bytes 0 to 50, unused fields left at zero
task automatic start_frame(input logic [15:0] port, input logic [7:0] ip_low,
	input logic [7:0] info);
	logic [31:0] ip;
	logic [15:0] eth;
	ip  = `GMII_DST_IP;
	eth = `GMII_ETH_TYPE;
	frame.delete();
	for (int i = 0; i <= `GMII_INFO_OFS; i++)
		frame.push_back(i < 7 ? 8'h55 : 8'h00);
	frame[7]  = 8'hd5;
	frame[20] = eth[15:8];
	frame[21] = eth[7:0];
	frame[22] = `GMII_IP_VER;
	frame[31] = `GMII_IP_PROTO;
	frame[38] = ip[31:24];
	frame[39] = ip[23:16];
	frame[40] = ip[15:8];
	frame[41] = ip_low;
	frame[44] = port[15:8];
	frame[45] = port[7:0];
	frame[`GMII_INFO_OFS] = info;
endtask

task automatic pad_frame(input int n);
	for (int i = 0; i < n; i++)
		frame.push_back(rand_byte());
endtask

task automatic send_frame(input int len);
	for (int i = 0; i < len; i++) begin
		@(posedge clk125);
		#10;
		rxd   = frame[i];
		rx_dv = 1'b1;
	end
	@(posedge clk125);
	#10;
	rxd   = 8'h00;
	rx_dv = 1'b0;
	repeat (GAP_CYCLES) @(posedge clk125);
endtask

`endif

//--- tb_gmii_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "gmii_rx_params.svh"

module tb_gmii_rx
	import gmii_rx_pkg::*;
();

	localparam int GAP_CYCLES   = 12;
	localparam int FRAME_CYCLES = 1400;
	// eight frames over the five tests, plus reset
	localparam int MAX_CYCLES   = 8 * FRAME_CYCLES + 200;
	localparam logic [15:0] GOOD_PORT = `GMII_DST_PORT;
	localparam logic [31:0] BASE_IP   = `GMII_DST_IP;

	logic        clk125;
	logic        sys_rst;
	logic        board_id;
	logic [7:0]  rxd;
	logic        rx_dv;
	logic        video_valid;
	video_word_t video;
	logic        aux_valid;
	aux_word_t   aux;
	logic        video_done;
	logic        aux_done;

	// {last, word} in arrival order
	logic [28:0] exp_video[$];
	logic [28:0] exp_aux[$];
	int          tests;
	int          checks;
	int          errors;
	int          test_errors;
	int          cycles;

	`include "tb_packet_gen.svh"

	gmii_rx_top i_dut (
		.clk125      (clk125),
		.sys_rst     (sys_rst),
		.board_id    (board_id),
		.rxd         (rxd),
		.rx_dv       (rx_dv),
		.video_valid (video_valid),
		.video       (video),
		.aux_valid   (aux_valid),
		.aux         (aux),
		.video_done  (video_done),
		.aux_done    (aux_done)
	);

	initial begin
		clk125 = 1'b0;
		forever #50 clk125 = ~clk125;
	end

	// ------------------------------------------------------------
	// expected payload, built from the frame layout
	// ------------------------------------------------------------
	function automatic logic [7:0] dst_low();
		return BASE_IP[7:0] + {7'd0, board_id};
	endfunction

	// line bytes, 598 pairs, then filler up to the aux start
	task automatic add_video(input int n_exp);
		logic [7:0]  lo;
		logic [7:0]  hi;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [10:0] line;
		lo = rand_byte();
		hi = rand_byte();
		frame.push_back(lo);
		frame.push_back(hi);
		// 11-bit line field keeps three of the upper bits
		line = {hi[2:0], lo};
		for (int k = 0; k < 598; k++) begin
			a = rand_byte();
			b = rand_byte();
			frame.push_back(a);
			frame.push_back(b);
			if (k < n_exp)
				exp_video.push_back({k == 597, hi[4], line, a, b});
		end
		while (frame.size() < `GMII_VIDEO_END)
			frame.push_back(rand_byte());
	endtask

	task automatic add_aux_block(input logic [15:0] pos, input logic last_blk);
		logic [287:0] bits;
		frame.push_back(pos[7:0]);
		frame.push_back(pos[15:8]);
		for (int i = 0; i < `GMII_AUX_BLOCK; i++) begin
			bits[8*i +: 8] = rand_byte();
			frame.push_back(bits[8*i +: 8]);
		end
		// lsb first, sample j is bits 9j to 9j+8
		for (int j = 0; j < 32; j++)
			exp_aux.push_back({last_blk && j == 31, 3'd0, pos, bits[9*j +: 9]});
	endtask

	// ------------------------------------------------------------
	// output monitors
	// ------------------------------------------------------------
	task automatic check_video();
		logic [28:0] exp;
		checks++;
		assert (exp_video.size() != 0) else begin
			errors++;
			$display("video word %h at %0t ns while none was expected", video, $time);
		end
		if (exp_video.size() != 0) begin
			exp = exp_video.pop_front();
			assert (video == exp[27:0]) else begin
				errors++;
				$display("Fail %0t video got %h expected %h", $time, video, exp[27:0]);
			end
			assert (video_done == exp[28]) else begin
				errors++;
				$display("Fail %0t video_done got %b expected %b", $time, video_done, exp[28]);
			end
		end
	endtask

	task automatic check_aux();
		logic [28:0] exp;
		checks++;
		assert (exp_aux.size() != 0) else begin
			errors++;
			$display("aux word %h at %0t ns while none was expected", aux, $time);
		end
		if (exp_aux.size() != 0) begin
			exp = exp_aux.pop_front();
			assert (aux == exp[27:0]) else begin
				errors++;
				$display("Fail %0t aux got %h expected %h", $time, aux, exp[27:0]);
			end
			assert (aux_done == exp[28]) else begin
				errors++;
				$display("Fail %0t aux_done got %b expected %b", $time, aux_done, exp[28]);
			end
		end
	endtask

	always @(negedge clk125) begin
		if (!sys_rst) begin
			if (video_valid)
				check_video();
			if (aux_valid)
				check_aux();
			assert ((!video_done || video_valid) && (!aux_done || aux_valid)) else begin
				errors++;
				$display("done pulse at %0t ns without its valid", $time);
			end
		end
	end

	task automatic end_test(input string name);
		while (exp_video.size() != 0 || exp_aux.size() != 0)
			@(posedge clk125);
		// stray words still land in this test
		repeat (4) @(posedge clk125);
		tests++;
		$display("test %s: %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic video_test();
		start_frame(GOOD_PORT, dst_low(), {4'd0, MODE_VIDEO});
		add_video(598);
		pad_frame(4);
		send_frame(frame.size());
		end_test("video");
	endtask

	task automatic address_test();
		start_frame(GOOD_PORT + 16'd1, dst_low(), {4'd0, MODE_VIDEO});
		add_video(0);
		pad_frame(4);
		send_frame(frame.size());
		#10;
		board_id = 1'b1;
		// base address without the board offset
		start_frame(GOOD_PORT, BASE_IP[7:0], {4'd0, MODE_VIDEO});
		add_video(0);
		pad_frame(4);
		send_frame(frame.size());
		start_frame(GOOD_PORT, dst_low(), {4'd0, MODE_VIDEO});
		add_video(598);
		pad_frame(4);
		send_frame(frame.size());
		end_test("address");
	endtask

	task automatic audio_test();
		start_frame(GOOD_PORT, dst_low(), {4'd2, MODE_AUDIO});
		add_aux_block(16'h0120, 1'b0);
		add_aux_block(16'h0121, 1'b1);
		pad_frame(4);
		send_frame(frame.size());
		end_test("audio");
	endtask

	task automatic vidax_test();
		start_frame(GOOD_PORT, dst_low(), {4'd1, MODE_VIDAX});
		add_video(598);
		add_aux_block(16'h0200, 1'b1);
		pad_frame(4);
		send_frame(frame.size());
		end_test("vidax");
	endtask

	task automatic abort_test();
		// pairs finished by byte 399 are words 0 to 172
		start_frame(GOOD_PORT, dst_low(), {4'd0, MODE_VIDEO});
		add_video(173);
		pad_frame(4);
		send_frame(400);
		start_frame(GOOD_PORT, dst_low(), {4'd0, MODE_VIDEO});
		add_video(598);
		pad_frame(4);
		send_frame(frame.size());
		end_test("abort");
	endtask

	initial begin
		sys_rst     = 1'b1;
		board_id    = 1'b0;
		rxd         = 8'h00;
		rx_dv       = 1'b0;
		tests       = 0;
		checks      = 0;
		errors      = 0;
		test_errors = 0;
		repeat (5) @(posedge clk125);
		#10;
		sys_rst = 1'b0;
		video_test();
		address_test();
		audio_test();
		vidax_test();
		abort_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk125);
			cycles++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- udp_stream_parser.sv
`timescale 1ns/1ps
`default_nettype none
`include "gmii_rx_params.svh"

module udp_stream_parser
	import gmii_rx_pkg::*;
(
	input  logic        clk125,
	input  logic        sys_rst,
	input  logic        board_id,
	input  logic [7:0]  rxd,
	input  logic        rx_dv,
	output fifo_entry_t entry,
	output logic        wr
);

	localparam logic [31:0] DST_IP    = `GMII_DST_IP;
	localparam logic [10:0] INFO_OFS  = 11'(`GMII_INFO_OFS);
	localparam logic [10:0] VID_FIRST = INFO_OFS + 11'd3;
	// 598 pixel pairs, last one ends at byte 1248
	localparam logic [10:0] VID_LAST  = VID_FIRST + 11'd1195;
	localparam logic [10:0] VIDAX_PRE = 11'(`GMII_VIDEO_END - 1);
	localparam logic [5:0]  BLK_END   = 6'(`GMII_AUX_BLOCK - 1);

	localparam logic [2:0] AX_IDLE   = 3'd0;
	localparam logic [2:0] AX_POS_LO = 3'd1;
	localparam logic [2:0] AX_POS_HI = 3'd2;
	localparam logic [2:0] AX_DATA   = 3'd3;
	localparam logic [2:0] AX_DONE   = 3'd4;

	logic [10:0] byte_cnt;
	logic [15:0] eth_type;
	logic [7:0]  ip_ver;
	logic [7:0]  ip_proto;
	logic [31:0] dst_ip;
	logic [15:0] dst_port;
	logic        hdr_match;
	logic        hdr_ok;
	pkt_mode_t   mode;
	logic [3:0]  blk_n;

	logic        vid_on;
	logic        in_video;
	logic        pair_hi;
	logic [7:0]  pix_a_r;
	logic [10:0] line_r;
	logic        x_lsb_r;

	logic [2:0]  ax_state;
	logic        aux_start;
	logic        blk_last;
	logic [3:0]  blk_idx;
	logic [5:0]  dcnt;
	logic [15:0] pos_r;
	logic [7:0]  acc;
	logic [3:0]  bit_cnt;
	logic [15:0] shift_in;

	// ------------------------------------------------------------
	// byte counter and header capture
	// ------------------------------------------------------------
	assign hdr_match = eth_type == `GMII_ETH_TYPE && ip_ver == `GMII_IP_VER &&
		ip_proto == `GMII_IP_PROTO && dst_ip[31:8] == DST_IP[31:8] &&
		dst_ip[7:0] == DST_IP[7:0] + {7'd0, board_id} && dst_port == `GMII_DST_PORT;

	always_ff @(posedge clk125) begin
		if (sys_rst || !rx_dv) begin
			byte_cnt <= '0;
			hdr_ok   <= 1'b0;
			mode     <= MODE_VIDEO;
			blk_n    <= '0;
		end else begin
			// saturate on oversized frames
			if (byte_cnt != '1)
				byte_cnt <= byte_cnt + 11'd1;
			if (byte_cnt == INFO_OFS && hdr_match) begin
				hdr_ok <= 1'b1;
				mode   <= pkt_mode_t'(rxd[3:0]);
				blk_n  <= rxd[7:4];
			end
		end
	end

	always_ff @(posedge clk125) begin
		case (byte_cnt)
			11'd20: eth_type[15:8] <= rxd;
			11'd21: eth_type[7:0]  <= rxd;
			11'd22: ip_ver         <= rxd;
			11'd31: ip_proto       <= rxd;
			11'd38: dst_ip[31:24]  <= rxd;
			11'd39: dst_ip[23:16]  <= rxd;
			11'd40: dst_ip[15:8]   <= rxd;
			11'd41: dst_ip[7:0]    <= rxd;
			11'd44: dst_port[15:8] <= rxd;
			11'd45: dst_port[7:0]  <= rxd;
			11'd51: line_r[7:0]    <= rxd;
			11'd52: begin
				// upper line bits in the low nibble, only 3 fit the field
				line_r[10:8] <= rxd[2:0];
				x_lsb_r      <= rxd[4];
			end
			default: ;
		endcase
	end

	// ------------------------------------------------------------
	// video pairs and aux unpacking into fifo entries
	// ------------------------------------------------------------
	assign vid_on   = hdr_ok && (mode == MODE_VIDEO || mode == MODE_VIDAX);
	assign in_video = vid_on && byte_cnt >= VID_FIRST && byte_cnt <= VID_LAST;

	// audio starts right after the info byte, vidax after the video area
	assign aux_start = (byte_cnt == INFO_OFS && hdr_match && rxd[3:0] == MODE_AUDIO &&
		rxd[7:4] != 4'd0) || (byte_cnt == VIDAX_PRE && hdr_ok && mode == MODE_VIDAX &&
		blk_n != 4'd0);
	assign blk_last = blk_idx == blk_n - 4'd1;

	// leftover bits sit below the new byte
	assign shift_in = ({8'd0, rxd} << bit_cnt) | {8'd0, acc};

	always_ff @(posedge clk125) begin
		if (sys_rst || !rx_dv) begin
			wr       <= 1'b0;
			pair_hi  <= 1'b0;
			ax_state <= AX_IDLE;
			blk_idx  <= '0;
			dcnt     <= '0;
			bit_cnt  <= '0;
		end else begin
			wr <= 1'b0;

			if (in_video) begin
				pair_hi <= !pair_hi;
				if (pair_hi) begin
					wr                <= 1'b1;
					entry.is_aux      <= 1'b0;
					entry.last        <= byte_cnt == VID_LAST;
					entry.body.video  <= {x_lsb_r, line_r, pix_a_r, rxd};
				end else begin
					pix_a_r <= rxd;
				end
			end else begin
				pair_hi <= 1'b0;
			end

			case (ax_state)
				AX_IDLE: begin
					if (aux_start)
						ax_state <= AX_POS_LO;
				end
				AX_POS_LO: begin
					pos_r[7:0] <= rxd;
					ax_state   <= AX_POS_HI;
				end
				AX_POS_HI: begin
					pos_r[15:8] <= rxd;
					dcnt        <= '0;
					bit_cnt     <= '0;
					ax_state    <= AX_DATA;
				end
				AX_DATA: begin
					dcnt <= dcnt + 6'd1;
					// nine phases, only phase 0 lacks a full sample
					if (bit_cnt == 4'd0) begin
						acc     <= rxd;
						bit_cnt <= 4'd8;
					end else begin
						acc            <= {1'b0, shift_in[15:9]};
						bit_cnt        <= bit_cnt - 4'd1;
						wr             <= 1'b1;
						entry.is_aux   <= 1'b1;
						entry.last     <= blk_last && dcnt == BLK_END;
						entry.body.aux <= {3'd0, pos_r, shift_in[8:0]};
					end
					if (dcnt == BLK_END) begin
						if (blk_last) begin
							ax_state <= AX_DONE;
						end else begin
							blk_idx  <= blk_idx + 4'd1;
							ax_state <= AX_POS_LO;
						end
					end
				end
				default: ax_state <= AX_DONE;
			endcase
		end
	end

	// video writes leave a gap for the fifo drain
	a_video_spacing: assert property (@(posedge clk125) disable iff (sys_rst)
		(wr && !entry.is_aux) |=> !wr);

endmodule

`default_nettype wire
